// File: compile.f
hw/cache_pkg.sv
hw/req_decode.sv
hw/l1_array.sv
hw/victim_cache.sv
hw/cache_ctrl.sv
hw/word_select.sv
hw/cache_top.sv
sim/cache_props.sv
sim/tb_cache.sv

// File: hw/cache_ctrl.sv
/*
 * execute stage controller
 * lookup in main array and victim store, swap on victim hit,
 * refill from memory with eviction of the old line
 */
module cache_ctrl import cache_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      dec_valid,
    input  dec_req_t  dec,

    // main array
    output index_t    rd_index,
    input  logic      rd_valid,
    input  tag_t      rd_tag,
    input  line_t     rd_line,
    output logic      wr_en,
    output index_t    wr_index,
    output tag_t      wr_tag,
    output line_t     wr_line,

    // victim store
    output line_key_t lookup_key,
    input  logic      hit,
    input  line_t     hit_line,
    output logic      swap,
    output logic      swap_valid,
    output line_key_t swap_key,
    output line_t     swap_line,
    output logic      insert,
    output line_key_t ins_key,
    output line_t     ins_line,

    // memory port
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_resp_valid,
    input  line_t     mem_line,

    // towards word selection
    output logic      res_valid,
    output line_t     res_line,
    output offset_t   res_offset,
    output resp_src_t res_src
);

    ctrl_state_t state;
    ctrl_state_t cur_state;
    dec_req_t    pend;
    line_t       refill_line;
    line_key_t   evict_key;
    logic        l1_hit;

    // a decoded strobe in IDLE is the lookup cycle itself
    assign cur_state = (state == IDLE && dec_valid) ? LOOKUP : state;

    assign rd_index   = (cur_state == LOOKUP) ? dec.index : pend.index;
    assign res_offset = (cur_state == LOOKUP) ? dec.offset : pend.offset;
    assign lookup_key = {dec.tag, dec.index};
    assign l1_hit     = rd_valid && (rd_tag == dec.tag);

    // line currently in the main array leaves towards the victim store
    assign evict_key  = {rd_tag, rd_index};
    assign swap_valid = rd_valid;
    assign swap_key   = evict_key;
    assign swap_line  = rd_line;
    assign ins_key    = evict_key;
    assign ins_line   = rd_line;

    always_comb begin
        wr_en     = 1'b0;
        wr_index  = pend.index;
        wr_tag    = pend.tag;
        wr_line   = refill_line;
        swap      = 1'b0;
        insert    = 1'b0;
        res_valid = 1'b0;
        res_line  = refill_line;
        res_src   = SRC_MEM;
        case (cur_state)
            LOOKUP: begin
                if (l1_hit) begin
                    res_valid = 1'b1;
                    res_line  = rd_line;
                    res_src   = SRC_L1;
                end else if (hit) begin
                    // exchange lines between the two arrays
                    swap      = 1'b1;
                    wr_en     = 1'b1;
                    wr_index  = dec.index;
                    wr_tag    = dec.tag;
                    wr_line   = hit_line;
                    res_valid = 1'b1;
                    res_line  = hit_line;
                    res_src   = SRC_VICTIM;
                end
            end
            REFILL_DONE: begin
                wr_en     = 1'b1;
                insert    = rd_valid;
                res_valid = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= IDLE;
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= 1'b0;
            case (cur_state)
                LOOKUP: begin
                    if (!l1_hit && !hit) begin
                        state         <= REFILL_WAIT;
                        mem_req_valid <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                REFILL_WAIT: begin
                    if (mem_resp_valid) begin
                        state <= REFILL_DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // pending request and the returned line
    always_ff @(posedge clk) begin
        if (cur_state == LOOKUP) begin
            pend        <= dec;
            mem_req.key <= {dec.tag, dec.index};
        end
        if (state == REFILL_WAIT && mem_resp_valid) begin
            refill_line <= mem_line;
        end
    end

endmodule

// File: hw/cache_pkg.sv
/*
 * shared cache types
 * address field vectors, line and word vectors
 * decoded request and refill request structs
 * response source and controller state enums
 */
package cache_pkg;

    // byte address and its fields
    typedef logic [31:0]  addr_t;
    typedef logic [19:0]  tag_t;
    typedef logic [5:0]   index_t;
    typedef logic [3:0]   offset_t;

    // tag and index together, the line address
    typedef logic [25:0]  line_key_t;

    typedef logic [511:0] line_t;
    typedef logic [31:0]  word_t;

    // decoded request, byte bits dropped
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } dec_req_t;

    // refill request towards memory
    typedef struct packed {
        line_key_t key;
    } mem_req_t;

    typedef enum logic [1:0] {
        SRC_L1     = 2'd0,
        SRC_VICTIM = 2'd1,
        SRC_MEM    = 2'd2
    } resp_src_t;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        LOOKUP      = 2'd1,
        REFILL_WAIT = 2'd2,
        REFILL_DONE = 2'd3
    } ctrl_state_t;

endpackage

// File: hw/cache_top.sv
/*
 * cache subsystem top level
 * request decode, controller with main array and victim store, word select
 */
module cache_top import cache_pkg::*; #(
    parameter int VICTIM_ENTRIES = 4
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      req_valid,
    input  addr_t     req_addr,
    output logic      resp_valid,
    output word_t     resp_data,
    output resp_src_t resp_src,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_resp_valid,
    input  line_t     mem_line
);

    logic      dec_valid;
    dec_req_t  dec;

    index_t    rd_index;
    logic      rd_valid;
    tag_t      rd_tag;
    line_t     rd_line;
    logic      wr_en;
    index_t    wr_index;
    tag_t      wr_tag;
    line_t     wr_line;

    line_key_t lookup_key;
    logic      hit;
    line_t     hit_line;
    logic      swap;
    logic      swap_valid;
    line_key_t swap_key;
    line_t     swap_line;
    logic      insert;
    line_key_t ins_key;
    line_t     ins_line;

    logic      res_valid;
    line_t     res_line;
    offset_t   res_offset;
    resp_src_t res_src;

    req_decode req_decode_inst (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    cache_ctrl cache_ctrl_inst (
        .clk            (clk),
        .rstn           (rstn),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .rd_index       (rd_index),
        .rd_valid       (rd_valid),
        .rd_tag         (rd_tag),
        .rd_line        (rd_line),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_tag         (wr_tag),
        .wr_line        (wr_line),
        .lookup_key     (lookup_key),
        .hit            (hit),
        .hit_line       (hit_line),
        .swap           (swap),
        .swap_valid     (swap_valid),
        .swap_key       (swap_key),
        .swap_line      (swap_line),
        .insert         (insert),
        .ins_key        (ins_key),
        .ins_line       (ins_line),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_line       (mem_line),
        .res_valid      (res_valid),
        .res_line       (res_line),
        .res_offset     (res_offset),
        .res_src        (res_src)
    );

    l1_array l1_array_inst (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag),
        .rd_line  (rd_line),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line)
    );

    victim_cache #(
        .VICTIM_ENTRIES (VICTIM_ENTRIES)
    ) victim_cache_inst (
        .clk        (clk),
        .rstn       (rstn),
        .lookup_key (lookup_key),
        .hit        (hit),
        .hit_line   (hit_line),
        .swap       (swap),
        .swap_valid (swap_valid),
        .swap_key   (swap_key),
        .swap_line  (swap_line),
        .insert     (insert),
        .ins_key    (ins_key),
        .ins_line   (ins_line)
    );

    word_select word_select_inst (
        .clk        (clk),
        .rstn       (rstn),
        .res_valid  (res_valid),
        .res_line   (res_line),
        .res_offset (res_offset),
        .res_src    (res_src),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_src   (resp_src)
    );

endmodule

// File: hw/l1_array.sv
/*
 * direct-mapped main array
 * valid, tag and line storage for 64 sets
 * combinational read port, one write port
 */
module l1_array import cache_pkg::*; (
    input  logic   clk,
    input  logic   rstn,

    // read side
    input  index_t rd_index,
    output logic   rd_valid,
    output tag_t   rd_tag,
    output line_t  rd_line,

    // write side
    input  logic   wr_en,
    input  index_t wr_index,
    input  tag_t   wr_tag,
    input  line_t  wr_line
);

    localparam int SETS = 1 << $bits(index_t);

    logic [SETS-1:0] valid_bits;
    tag_t            tag_mem  [SETS];
    line_t           line_mem [SETS];

    // asynchronous read, the controller decides within the same cycle
    always_comb begin
        rd_valid = valid_bits[rd_index];
        rd_tag   = tag_mem[rd_index];
        rd_line  = line_mem[rd_index];
    end

    // only the valid bits need clearing
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
    end

endmodule

// File: hw/req_decode.sv
/*
 * request decode stage
 * registers the request strobe and address, splits tag, index, word offset
 */
module req_decode import cache_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     req_valid,
    input  addr_t    req_addr,
    output logic     dec_valid,
    output dec_req_t dec
);

    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB  = OFFSET_LSB + $bits(offset_t);
    localparam int TAG_LSB    = INDEX_LSB + $bits(index_t);

    dec_req_t dec_next;

    // address split, bits [1:0] are the byte within the word
    always_comb begin
        dec_next.tag    = req_addr[TAG_LSB +: $bits(tag_t)];
        dec_next.index  = req_addr[INDEX_LSB +: $bits(index_t)];
        dec_next.offset = req_addr[OFFSET_LSB +: $bits(offset_t)];
    end

    // strobe lasts exactly one cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    // fields stay put until the next request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec <= dec_next;
        end
    end

endmodule

// File: hw/victim_cache.sv
/*
 * fully associative victim store
 * parallel key compare with lowest slot priority
 * swap in place on a victim hit, FIFO insertion by wrapping counter
 */
module victim_cache import cache_pkg::*; #(
    parameter int VICTIM_ENTRIES = 4
) (
    input  logic      clk,
    input  logic      rstn,

    // lookup
    input  line_key_t lookup_key,
    output logic      hit,
    output line_t     hit_line,

    // swap with the line leaving the main array
    input  logic      swap,
    input  logic      swap_valid,
    input  line_key_t swap_key,
    input  line_t     swap_line,

    // insertion of an evicted line
    input  logic      insert,
    input  line_key_t ins_key,
    input  line_t     ins_line
);

    localparam int PTR_W = (VICTIM_ENTRIES > 1) ? $clog2(VICTIM_ENTRIES) : 1;

    logic [VICTIM_ENTRIES-1:0] slot_valid;
    line_key_t                 slot_key  [VICTIM_ENTRIES];
    line_t                     slot_line [VICTIM_ENTRIES];

    logic [VICTIM_ENTRIES-1:0] match;
    logic [PTR_W-1:0]          hit_idx;
    logic [PTR_W-1:0]          ins_ptr;

    always_comb begin
        for (int i = 0; i < VICTIM_ENTRIES; i++) begin
            match[i] = slot_valid[i] && (slot_key[i] == lookup_key);
        end
    end

    // walk downwards so the lowest matching slot is left in hit_idx
    always_comb begin
        hit_idx = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = PTR_W'(i);
            end
        end
    end

    assign hit      = |match;
    assign hit_line = slot_line[hit_idx];

    // control state, counter stays still on a swap
    always_ff @(posedge clk) begin
        if (!rstn) begin
            slot_valid <= '0;
            ins_ptr    <= '0;
        end else begin
            if (swap) begin
                slot_valid[hit_idx] <= swap_valid;
            end
            if (insert) begin
                slot_valid[ins_ptr] <= 1'b1;
                if (ins_ptr == PTR_W'(VICTIM_ENTRIES - 1)) begin
                    ins_ptr <= '0;
                end else begin
                    ins_ptr <= ins_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (swap) begin
            slot_key[hit_idx]  <= swap_key;
            slot_line[hit_idx] <= swap_line;
        end
        if (insert) begin
            slot_key[ins_ptr]  <= ins_key;
            slot_line[ins_ptr] <= ins_line;
        end
    end

endmodule

// File: hw/word_select.sv
/*
 * result stage
 * picks the addressed word from the line, registers the response
 */
module word_select import cache_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      res_valid,
    input  line_t     res_line,
    input  offset_t   res_offset,
    input  resp_src_t res_src,
    output logic      resp_valid,
    output word_t     resp_data,
    output resp_src_t resp_src
);

    localparam int WORD_W = $bits(word_t);

    word_t sel_word;

    // word k sits at bits 32k upward
    assign sel_word = res_line[res_offset * WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            resp_data <= sel_word;
            resp_src  <= res_src;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module tb_cache -f compile.f -o tb_cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/cache_props.sv
/*
 * handshake assertions, bound into the cache controller
 */
module cache_props (
    input logic clk,
    input logic rstn,
    input logic mem_req_valid,
    input logic mem_resp_valid,
    input logic res_valid
);

    // open from a refill request until memory answers
    logic refill_open;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            refill_open <= 1'b0;
        end else if (mem_req_valid) begin
            refill_open <= 1'b1;
        end else if (mem_resp_valid) begin
            refill_open <= 1'b0;
        end
    end

    mem_req_pulse: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid |=> !mem_req_valid)
        else $error("mem_req_valid stayed high for two cycles");

    res_pulse: assert property (@(posedge clk) disable iff (!rstn)
        res_valid |=> !res_valid)
        else $error("res_valid stayed high for two cycles");

    one_refill: assert property (@(posedge clk) disable iff (!rstn)
        refill_open |-> !mem_req_valid)
        else $error("second memory request before the memory response");

endmodule

bind cache_ctrl cache_props cache_props_inst (
    .clk            (clk),
    .rstn           (rstn),
    .mem_req_valid  (mem_req_valid),
    .mem_resp_valid (mem_resp_valid),
    .res_valid      (res_valid)
);

// File: sim/tb_cache.sv
/*
 * cache subsystem testbench
 * clock, reset, memory model with random latency
 * shadow model of main array and victim FIFO, directed and random reads
 */
module tb_cache import cache_pkg::*; ();

    localparam int VICTIM_ENTRIES = 4;
    localparam int NO_CHECK       = -1;
    localparam int NUM_REQS       = 8 + 8 + 8 + (VICTIM_ENTRIES + 4) + 300 + 2;
    localparam int MAX_CYCLES     = NUM_REQS * 20 + 200;
    localparam logic [31:0] SEED  = 32'h26d2_0cc1;
    localparam word_t DATA_MASK   = 32'h5a5a_0f0f;

    typedef struct packed {
        addr_t     addr;
        word_t     word;
        resp_src_t src;
        int        issued;
    } expect_t;

    logic      clk;
    logic      rstn;
    logic      req_valid;
    addr_t     req_addr;
    logic      resp_valid;
    word_t     resp_data;
    resp_src_t resp_src;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_resp_valid;
    line_t     mem_line;

    int          cycle_count = 0;
    int          sent = 0;
    int          resp_count = 0;
    int          data_errs = 0;
    int          src_errs = 0;
    int          lat_errs = 0;
    int          other_errs = 0;
    logic [31:0] mem_rng = SEED;
    logic [31:0] stim_rng = SEED;
    expect_t     exp_q[$];
    expect_t     cur_exp;
    line_key_t   mem_key;
    int          mem_delay;

    // shadow of the cache contents
    logic      sh_l1_valid [64];
    tag_t      sh_l1_tag   [64];
    logic      sh_v_valid  [VICTIM_ENTRIES];
    line_key_t sh_v_key    [VICTIM_ENTRIES];
    int        sh_v_ptr;

    cache_top #(
        .VICTIM_ENTRIES (VICTIM_ENTRIES)
    ) cache_top_inst (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_src       (resp_src),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_line       (mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic addr_t pack_addr(input tag_t tag, input index_t idx,
                                        input offset_t off, input logic [1:0] byte_sel);
        return {tag, idx, off, byte_sel};
    endfunction

    // expected word, the word aligned byte address under a fixed mask
    function automatic word_t ref_word(input addr_t addr);
        return {addr[31:2], 2'b00} ^ DATA_MASK;
    endfunction

    function automatic line_t build_line(input line_key_t key);
        line_t l;
        for (int k = 0; k < 16; k++) begin
            l[32*k +: 32] = {key, 4'(k), 2'b00} ^ DATA_MASK;
        end
        return l;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 64; i++) begin
            sh_l1_valid[i] = 1'b0;
            sh_l1_tag[i]   = '0;
        end
        for (int j = 0; j < VICTIM_ENTRIES; j++) begin
            sh_v_valid[j] = 1'b0;
            sh_v_key[j]   = '0;
        end
        sh_v_ptr = 0;
    endtask

    // predicts the source and updates the shadow
    task automatic model_access(input addr_t addr, output resp_src_t src);
        tag_t      tag;
        index_t    idx;
        line_key_t key;
        int        slot;
        tag  = addr[31:12];
        idx  = addr[11:6];
        key  = addr[31:6];
        slot = -1;
        for (int j = VICTIM_ENTRIES - 1; j >= 0; j--) begin
            if (sh_v_valid[j] && sh_v_key[j] == key) begin
                slot = j;
            end
        end
        if (sh_l1_valid[idx] && sh_l1_tag[idx] == tag) begin
            src = SRC_L1;
        end else if (slot >= 0) begin
            src = SRC_VICTIM;
            sh_v_valid[slot] = sh_l1_valid[idx];
            sh_v_key[slot]   = {sh_l1_tag[idx], idx};
        end else begin
            src = SRC_MEM;
            if (sh_l1_valid[idx]) begin
                sh_v_valid[sh_v_ptr] = 1'b1;
                sh_v_key[sh_v_ptr]   = {sh_l1_tag[idx], idx};
                sh_v_ptr = (sh_v_ptr + 1) % VICTIM_ENTRIES;
            end
        end
        sh_l1_valid[idx] = 1'b1;
        sh_l1_tag[idx]   = tag;
    endtask

    task automatic issue_read(input addr_t addr, input int want);
        expect_t   e;
        resp_src_t src;
        model_access(addr, src);
        if (want != NO_CHECK && want != int'(src)) begin
            other_errs++;
            $display("sequence expects source %0d for %h, shadow model gives %0d",
                     want, addr, src);
        end
        @(posedge clk);
        #5;
        e.addr   = addr;
        e.word   = ref_word(addr);
        e.src    = src;
        e.issued = cycle_count;
        exp_q.push_back(e);
        req_valid = 1'b1;
        req_addr  = addr;
        sent++;
        @(posedge clk);
        #5;
        req_valid = 1'b0;
        wait (resp_count == sent);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #5;
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rstn = 1'b1;
        model_reset();
    endtask

    task automatic report_counts();
        $display("errors: data %0d, source %0d, latency %0d, other %0d",
                 data_errs, src_errs, lat_errs, other_errs);
    endtask

    // memory answers after 1 to 4 cycles
    initial begin
        mem_resp_valid = 1'b0;
        mem_line       = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid) begin
                mem_key   = mem_req.key;
                mem_rng   = lcg_next(mem_rng);
                mem_delay = 1 + int'(mem_rng[31:30]);
                repeat (mem_delay) @(posedge clk);
                #5;
                mem_resp_valid = 1'b1;
                mem_line       = build_line(mem_key);
                @(posedge clk);
                #5;
                mem_resp_valid = 1'b0;
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (resp_valid) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("response at time %0t with no request outstanding", $time);
            end else begin
                cur_exp = exp_q.pop_front();
                if (resp_data !== cur_exp.word) begin
                    data_errs++;
                    $display("FAIL %0t: data for %h is %h, expected %h",
                             $time, cur_exp.addr, resp_data, cur_exp.word);
                end
                if (resp_src !== cur_exp.src) begin
                    src_errs++;
                    $display("FAIL %0t: source for %h is %0d, expected %0d",
                             $time, cur_exp.addr, resp_src, cur_exp.src);
                end
                if (cur_exp.src != SRC_MEM && cycle_count - cur_exp.issued != 2) begin
                    lat_errs++;
                    $display("FAIL %0t: hit latency for %h is %0d cycles, expected 2",
                             $time, cur_exp.addr, cycle_count - cur_exp.issued);
                end
                resp_count++;
            end
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) @(posedge clk);
        $display("timeout: only %0d of %0d responses arrived within %0d cycles",
                 resp_count, sent, MAX_CYCLES);
        report_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        addr_t addr_a;
        addr_t addr_b;
        addr_t addr_r;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #5;
        rstn = 1'b1;

        // cold reads, one per set
        for (int i = 0; i < 8; i++) begin
            issue_read(pack_addr(20'h00010, index_t'(i), offset_t'(i), 2'(i)), SRC_MEM);
        end

        // other words of the line in set 0
        for (int k = 8; k < 16; k++) begin
            issue_read(pack_addr(20'h00010, 6'd0, offset_t'(k), 2'd0), SRC_L1);
        end

        // two tags fighting over set 20
        addr_a = pack_addr(20'h00a11, 6'd20, 4'd3, 2'd0);
        addr_b = pack_addr(20'h00b22, 6'd20, 4'd1, 2'd2);
        issue_read(addr_a, SRC_MEM);
        issue_read(addr_a + 32'd24, SRC_L1);
        issue_read(addr_b, SRC_MEM);
        for (int i = 0; i < 5; i++) begin
            issue_read((i % 2 == 0) ? addr_a : addr_b, SRC_VICTIM);
        end

        // fill set 33 past the victim depth
        for (int t = 0; t < VICTIM_ENTRIES + 2; t++) begin
            issue_read(pack_addr(20'h30000 + tag_t'(t), 6'd33, 4'd5, 2'd0), SRC_MEM);
        end
        issue_read(pack_addr(20'h30000, 6'd33, 4'd6, 2'd0), SRC_MEM);
        issue_read(pack_addr(20'h30000 + tag_t'(VICTIM_ENTRIES - 1), 6'd33, 4'd2, 2'd1),
                   SRC_VICTIM);

        // random reads over 4 tags and 4 sets
        for (int i = 0; i < 300; i++) begin
            stim_rng = lcg_next(stim_rng);
            addr_r = pack_addr(tag_t'(stim_rng[29:28]), index_t'(stim_rng[25:24]),
                               stim_rng[21:18], stim_rng[17:16]);
            issue_read(addr_r, NO_CHECK);
        end

        // contents are gone after a reset
        apply_reset();
        issue_read(pack_addr(20'h00010, 6'd0, 4'd4, 2'd0), SRC_MEM);
        issue_read(pack_addr(20'h00010, 6'd0, 4'd7, 2'd0), SRC_L1);

        repeat (5) @(posedge clk);
        report_counts();
        if (data_errs + src_errs + lat_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
